// ==== include/wbuf_settings.svh ====
/*
 * write buffer sizing: entry count, transactions in flight, bus widths
 * and the widths derived from them
 */

`ifndef WBUF_SETTINGS_SVH
`define WBUF_SETTINGS_SVH

// buffer geometry
`define WBUF_DEPTH   4
`define WBUF_MAX_TX  2

// bus widths in bits
`define WBUF_ADDR_W  32
`define WBUF_DATA_W  64

// derived from the widths above
`define WBUF_BYTES   8
`define WBUF_OFF_W   3
`define WBUF_WADDR_W 29
`define WBUF_PTR_W   2
`define WBUF_TID_W   1

`endif

// ==== source/wbuf_entry_pkg.sv ====
/*
 * write buffer storage types: one buffer entry, one transaction slot,
 * and the rule that cuts sendable bytes into an aligned transfer
 */

`include "wbuf_settings.svh"

package wbuf_entry_pkg;

  typedef logic [`WBUF_BYTES-1:0] byte_mask_t;

  // per byte: valid/dirty/txblock
  // 000 free, 110 waiting to be sent, 101 in flight, 111 rewritten while in flight
  typedef struct packed {
    logic [`WBUF_WADDR_W-1:0] waddr;
    logic [`WBUF_DATA_W-1:0]  data;
    byte_mask_t               valid;
    byte_mask_t               dirty;
    byte_mask_t               txblock;
  } wbuf_entry_t;

  typedef struct packed {
    logic                   vld;
    byte_mask_t             be;
    logic [`WBUF_PTR_W-1:0] ptr;
  } tx_slot_t;

  // largest aligned 8/4/2/1 byte block at the lowest sendable byte
  // that is fully sendable, empty mask in gives empty mask out
  function automatic byte_mask_t tx_mask(byte_mask_t send);
    byte_mask_t  be;
    byte_mask_t  blk;
    int unsigned off;
    be  = '0;
    off = 0;
    for (int k = `WBUF_BYTES - 1; k >= 0; k--) begin
      if (send[k]) begin
        off = k;
      end
    end
    // try the widest block first
    for (int s = `WBUF_OFF_W; s >= 0; s--) begin
      blk = byte_mask_t'((1 << (1 << s)) - 1) << off;
      if ((be == '0) && ((off % (1 << s)) == 0) && ((send & blk) == blk)) begin
        be = blk;
      end
    end
    return be;
  endfunction

endpackage

// ==== source/wbuf_bus_pkg.sv ====
/*
 * write buffer port types: core store request, memory write request
 * and memory write response
 */

`include "wbuf_settings.svh"

package wbuf_bus_pkg;

  // core store, be selects bytes of the addressed 64-bit word
  typedef struct packed {
    logic                   valid;
    logic [`WBUF_ADDR_W-1:0] addr;
    logic [`WBUF_BYTES-1:0]  be;
    logic [`WBUF_DATA_W-1:0] data;
  } core_wreq_t;

  // memory write, size 0..3 means 1, 2, 4 or 8 bytes
  // data carries the whole word with every byte in its own lane
  typedef struct packed {
    logic                   valid;
    logic [`WBUF_ADDR_W-1:0] addr;
    logic [1:0]              size;
    logic [`WBUF_TID_W-1:0]  tid;
    logic [`WBUF_DATA_W-1:0] data;
  } mem_wreq_t;

  // write completion, one cycle strobe
  typedef struct packed {
    logic                  valid;
    logic [`WBUF_TID_W-1:0] tid;
  } mem_wrsp_t;

endpackage

// ==== source/rr_arbiter.sv ====
/*
 * round-robin arbiter, returns the index of the chosen requester
 * and holds that choice until it is granted
 */

`timescale 1ns/1ps

module rr_arbiter #(
  parameter int NUM_REQ = 4,
  localparam int IDX_W = (NUM_REQ > 1) ? $clog2(NUM_REQ) : 1
) (
  input  logic               clk_i,
  input  logic               rst_ni,
  input  logic [NUM_REQ-1:0] req_i,
  input  logic               gnt_i,
  output logic [IDX_W-1:0]   idx_o,
  output logic               vld_o
);

  logic [IDX_W-1:0] rr_q;
  logic [IDX_W-1:0] lock_idx_q;
  logic             lock_q;
  logic [IDX_W-1:0] pick;
  logic             found;

  // search starts right after the last granted requester
  // so the last winner gets the lowest priority
  always_comb begin : p_search
    int unsigned cand;
    pick  = rr_q;
    found = 1'b0;
    for (int unsigned i = 1; i <= NUM_REQ; i++) begin
      cand = (32'(rr_q) + i) % NUM_REQ;
      if (!found && req_i[cand]) begin
        pick  = IDX_W'(cand);
        found = 1'b1;
      end
    end
  end

  // a pending choice stays put until gnt_i
  assign idx_o = lock_q ? lock_idx_q : pick;
  assign vld_o = lock_q ? req_i[lock_idx_q] : found;

  always_ff @(posedge clk_i or negedge rst_ni) begin : p_regs
    if (!rst_ni) begin
      rr_q       <= '0;
      lock_q     <= 1'b0;
      lock_idx_q <= '0;
    end else if (vld_o && gnt_i) begin
      rr_q   <= idx_o;
      lock_q <= 1'b0;
    end else if (vld_o) begin
      lock_q     <= 1'b1;
      lock_idx_q <= idx_o;
    end
  end

  // the owner of a held choice keeps requesting until served
  a_lock_held: assert property (@(posedge clk_i) disable iff (!rst_ni)
    lock_q |-> req_i[lock_idx_q])
    else $error("rr_arbiter: locked requester dropped its request");

endmodule

// ==== source/wbuf_store.sv ====
/*
 * write buffer entries: hit and free search, coalescing of core writes,
 * per-byte valid/dirty/in-flight tracking on take and evict
 */

`timescale 1ns/1ps
`include "wbuf_settings.svh"

module wbuf_store
  import wbuf_entry_pkg::*;
  import wbuf_bus_pkg::*;
(
  input  logic                                clk_i,
  input  logic                                rst_ni,
  input  core_wreq_t                          core_req_i,
  output logic                                core_gnt_o,
  input  logic                                take_i,
  input  logic [`WBUF_PTR_W-1:0]              take_ptr_i,
  input  byte_mask_t                          take_be_i,
  input  logic                                evict_i,
  input  logic [`WBUF_PTR_W-1:0]              evict_ptr_i,
  input  byte_mask_t                          evict_be_i,
  output wbuf_entry_t [`WBUF_DEPTH-1:0]       entries_o,
  output byte_mask_t [`WBUF_DEPTH-1:0]        sendable_o,
  output logic                                empty_o
);

  localparam int PTR_W = `WBUF_PTR_W;

  logic [`WBUF_DEPTH-1:0][`WBUF_WADDR_W-1:0] waddr_q;
  logic [`WBUF_DEPTH-1:0][`WBUF_DATA_W-1:0]  data_q;
  byte_mask_t [`WBUF_DEPTH-1:0]              valid_q, valid_d;
  byte_mask_t [`WBUF_DEPTH-1:0]              dirty_q, dirty_d;
  byte_mask_t [`WBUF_DEPTH-1:0]              txblock_q, txblock_d;
  byte_mask_t [`WBUF_DEPTH-1:0]              send;

  logic [`WBUF_WADDR_W-1:0] req_waddr;
  logic [`WBUF_DEPTH-1:0]   hit;
  logic [`WBUF_DEPTH-1:0]   free;
  logic [PTR_W-1:0]         hit_ptr, free_ptr, wr_ptr;
  logic                     offer_wait;
  logic                     hold_conflict;

  assign req_waddr = core_req_i.addr[`WBUF_ADDR_W-1:`WBUF_OFF_W];

  ////////////////////////////////////////
  // per entry flags
  ////////////////////////////////////////

  for (genvar k = 0; k < `WBUF_DEPTH; k++) begin : gen_flags
    assign hit[k]  = (|valid_q[k]) && (waddr_q[k] == req_waddr);
    assign free[k] = ~|valid_q[k];
    // an entry with any byte in flight sends nothing, so two writes
    // to the same word can never overtake each other in memory
    assign send[k] = (|txblock_q[k]) ? '0 : (dirty_q[k] & valid_q[k]);
    assign entries_o[k] = '{waddr:   waddr_q[k],
                            data:    data_q[k],
                            valid:   valid_q[k],
                            dirty:   dirty_q[k],
                            txblock: txblock_q[k]};
  end

  assign sendable_o = send;
  assign empty_o    = ~|valid_q;

  // lowest index wins in both searches
  always_comb begin : p_ptr
    hit_ptr  = '0;
    free_ptr = '0;
    for (int k = `WBUF_DEPTH - 1; k >= 0; k--) begin
      if (hit[k]) begin
        hit_ptr = PTR_W'(k);
      end
      if (free[k]) begin
        free_ptr = PTR_W'(k);
      end
    end
  end

  assign wr_ptr = (|hit) ? hit_ptr : free_ptr;

  ////////////////////////////////////////
  // core grant
  ////////////////////////////////////////

  // take_be_i is nonzero while a transfer is offered to memory
  // the offered entry may still merge, as long as bytes and shape of the
  // offered transfer stay the same
  assign offer_wait    = (|take_be_i) && !take_i;
  assign hold_conflict = offer_wait && hit[take_ptr_i] &&
                         (((core_req_i.be & take_be_i) != '0) ||
                          (tx_mask(send[take_ptr_i] | core_req_i.be) != take_be_i));

  assign core_gnt_o = core_req_i.valid && ((|hit) || (|free)) && !hold_conflict;

  ////////////////////////////////////////
  // byte state update
  ////////////////////////////////////////

  always_comb begin : p_state
    valid_d   = valid_q;
    dirty_d   = dirty_q;
    txblock_d = txblock_q;
    // returned bytes leave flight, untouched ones are freed
    if (evict_i) begin
      txblock_d[evict_ptr_i] = txblock_q[evict_ptr_i] & ~evict_be_i;
      valid_d[evict_ptr_i]   = valid_q[evict_ptr_i] & ~(evict_be_i & ~dirty_q[evict_ptr_i]);
    end
    // accepted transfer, dirty -> in flight
    if (take_i) begin
      dirty_d[take_ptr_i]   = dirty_d[take_ptr_i] & ~take_be_i;
      txblock_d[take_ptr_i] = txblock_d[take_ptr_i] | take_be_i;
    end
    // core write last, so a byte rewritten this cycle ends up dirty
    if (core_gnt_o) begin
      valid_d[wr_ptr] = valid_d[wr_ptr] | core_req_i.be;
      dirty_d[wr_ptr] = dirty_d[wr_ptr] | core_req_i.be;
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin : p_state_regs
    if (!rst_ni) begin
      valid_q   <= '0;
      dirty_q   <= '0;
      txblock_q <= '0;
    end else begin
      valid_q   <= valid_d;
      dirty_q   <= dirty_d;
      txblock_q <= txblock_d;
    end
  end

  // word address and merged data bytes
  always_ff @(posedge clk_i) begin : p_payload
    if (core_gnt_o) begin
      waddr_q[wr_ptr] <= req_waddr;
      for (int j = 0; j < `WBUF_BYTES; j++) begin
        if (core_req_i.be[j]) begin
          data_q[wr_ptr][8*j +: 8] <= core_req_i.data[8*j +: 8];
        end
      end
    end
  end

  a_hit_onehot: assert property (@(posedge clk_i) disable iff (!rst_ni)
    $onehot0(hit))
    else $error("wbuf_store: word held by more than one entry");

  // issue and tracker must never point at the same bytes at once
  a_take_evict: assert property (@(posedge clk_i) disable iff (!rst_ni)
    (take_i && evict_i && (take_ptr_i == evict_ptr_i)) |-> ((take_be_i & evict_be_i) == '0))
    else $error("wbuf_store: take and evict on the same bytes");

  for (genvar k = 0; k < `WBUF_DEPTH; k++) begin : gen_state_chk
    for (genvar j = 0; j < `WBUF_BYTES; j++) begin : gen_byte
      a_byte_state: assert property (@(posedge clk_i) disable iff (!rst_ni)
        {valid_q[k][j], dirty_q[k][j], txblock_q[k][j]} inside
          {3'b000, 3'b110, 3'b101, 3'b111})
        else $error("wbuf_store: entry %0d byte %0d in illegal state", k, j);
    end
  end

endmodule

// ==== source/wbuf_tx_issue.sv ====
/*
 * transfer issue: cuts the chosen entry's sendable bytes into one
 * naturally aligned transfer and drives the memory write request
 */

`timescale 1ns/1ps
`include "wbuf_settings.svh"

module wbuf_tx_issue
  import wbuf_entry_pkg::*;
  import wbuf_bus_pkg::*;
(
  input  wbuf_entry_t            entry_i,
  input  byte_mask_t             sendable_i,
  input  logic                   sel_vld_i,
  input  logic                   slot_free_i,
  input  logic [`WBUF_TID_W-1:0] tid_i,
  output mem_wreq_t              mem_wreq_o,
  input  logic                   mem_ack_i,
  output logic                   take_o,
  output byte_mask_t             take_be_o
);

  localparam int OFF_W = `WBUF_OFF_W;

  byte_mask_t       tx_be;
  logic [OFF_W-1:0] tx_off;
  logic [1:0]       tx_size;
  logic             req_vld;

  // e.g. sendable 0011_1001 gives 0000_0001 now, then 0000_1000, then 0011_0000
  assign tx_be = tx_mask(sendable_i);

  // offset is the first byte of the block
  always_comb begin : p_off
    tx_off = '0;
    for (int k = `WBUF_BYTES - 1; k >= 0; k--) begin
      if (tx_be[k]) begin
        tx_off = OFF_W'(k);
      end
    end
  end

  // block length to size code
  always_comb begin : p_size
    case ($countones(tx_be))
      8:       tx_size = 2'd3;
      4:       tx_size = 2'd2;
      2:       tx_size = 2'd1;
      default: tx_size = 2'd0;
    endcase
  end

  // need something to send and a free transaction slot
  assign req_vld = sel_vld_i && slot_free_i;

  assign mem_wreq_o.valid = req_vld;
  assign mem_wreq_o.addr  = {entry_i.waddr, tx_off};
  assign mem_wreq_o.size  = tx_size;
  assign mem_wreq_o.tid   = tid_i;
  // full word, bytes outside the transfer are don't care
  assign mem_wreq_o.data  = entry_i.data;

  assign take_o = req_vld && mem_ack_i;
  // also tells the store which bytes are on offer
  assign take_be_o = req_vld ? tx_be : '0;

endmodule

// ==== source/wbuf_tx_tracker.sv ====
/*
 * transaction tracking: slot table of transfers in flight, queue of
 * returned IDs, and eviction of the bytes of each returned transfer
 */

`timescale 1ns/1ps
`include "wbuf_settings.svh"

module wbuf_tx_tracker
  import wbuf_entry_pkg::*;
  import wbuf_bus_pkg::*;
(
  input  logic                    clk_i,
  input  logic                    rst_ni,
  input  logic                    take_i,
  input  logic [`WBUF_PTR_W-1:0]  take_ptr_i,
  input  byte_mask_t              take_be_i,
  input  logic [`WBUF_TID_W-1:0]  tid_i,
  input  mem_wrsp_t               mem_wrsp_i,
  output logic [`WBUF_MAX_TX-1:0] slot_free_o,
  output logic                    evict_o,
  output logic [`WBUF_PTR_W-1:0]  evict_ptr_o,
  output byte_mask_t              evict_be_o
);

  localparam int QPTR_W = (`WBUF_MAX_TX > 1) ? $clog2(`WBUF_MAX_TX) : 1;
  localparam int CNT_W  = $clog2(`WBUF_MAX_TX + 1);
  localparam logic [QPTR_W-1:0] QLAST = QPTR_W'(`WBUF_MAX_TX - 1);

  tx_slot_t [`WBUF_MAX_TX-1:0]                   slot_q, slot_d;
  logic [`WBUF_MAX_TX-1:0][`WBUF_TID_W-1:0]      rtrn_q;
  logic [QPTR_W-1:0]                             rd_ptr_q, wr_ptr_q;
  logic [CNT_W-1:0]                              cnt_q;
  logic [`WBUF_TID_W-1:0]                        head_id;
  logic                                          pop;

  ////////////////////////////////////////
  // returned ID queue
  ////////////////////////////////////////

  // one pop per cycle, a response is seen here one cycle after its strobe
  assign pop     = (cnt_q != '0);
  assign head_id = rtrn_q[rd_ptr_q];

  always_ff @(posedge clk_i or negedge rst_ni) begin : p_queue_ctrl
    if (!rst_ni) begin
      rd_ptr_q <= '0;
      wr_ptr_q <= '0;
      cnt_q    <= '0;
    end else begin
      if (mem_wrsp_i.valid) begin
        wr_ptr_q <= (wr_ptr_q == QLAST) ? '0 : wr_ptr_q + 1'b1;
      end
      if (pop) begin
        rd_ptr_q <= (rd_ptr_q == QLAST) ? '0 : rd_ptr_q + 1'b1;
      end
      cnt_q <= cnt_q + CNT_W'(mem_wrsp_i.valid) - CNT_W'(pop);
    end
  end

  always_ff @(posedge clk_i) begin : p_queue_data
    if (mem_wrsp_i.valid) begin
      rtrn_q[wr_ptr_q] <= mem_wrsp_i.tid;
    end
  end

  ////////////////////////////////////////
  // slot table
  ////////////////////////////////////////

  // the popped slot is busy and the slot being taken is free,
  // so the two updates never hit the same slot
  always_comb begin : p_slots
    slot_d = slot_q;
    if (pop) begin
      slot_d[head_id].vld = 1'b0;
    end
    if (take_i) begin
      slot_d[tid_i] = '{vld: 1'b1, be: take_be_i, ptr: take_ptr_i};
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin : p_slot_regs
    if (!rst_ni) begin
      slot_q <= '0;
    end else begin
      slot_q <= slot_d;
    end
  end

  for (genvar k = 0; k < `WBUF_MAX_TX; k++) begin : gen_free
    assign slot_free_o[k] = ~slot_q[k].vld;
  end

  assign evict_o     = pop;
  assign evict_ptr_o = slot_q[head_id].ptr;
  assign evict_be_o  = slot_q[head_id].be;

  // memory answers only IDs that were issued and not yet retired
  a_rsp_busy: assert property (@(posedge clk_i) disable iff (!rst_ni)
    mem_wrsp_i.valid |-> slot_q[mem_wrsp_i.tid].vld)
    else $error("wbuf_tx_tracker: response for free slot %0d", mem_wrsp_i.tid);

endmodule

// ==== source/write_buffer.sv ====
/*
 * coalescing write buffer: merges core stores per 64-bit word and
 * drains them to memory as aligned transfers with out-of-order responses
 */

`timescale 1ns/1ps
`include "wbuf_settings.svh"

module write_buffer
  import wbuf_entry_pkg::*;
  import wbuf_bus_pkg::*;
(
  input  logic       clk_i,
  input  logic       rst_ni,
  input  core_wreq_t core_req_i,
  output logic       core_gnt_o,
  output mem_wreq_t  mem_wreq_o,
  input  logic       mem_ack_i,
  input  mem_wrsp_t  mem_wrsp_i,
  output logic       empty_o
);

  wbuf_entry_t [`WBUF_DEPTH-1:0] entries;
  byte_mask_t [`WBUF_DEPTH-1:0]  sendable;
  logic [`WBUF_DEPTH-1:0]        dirty_req;
  logic [`WBUF_PTR_W-1:0]        dirty_idx;
  logic                          dirty_vld;
  logic [`WBUF_MAX_TX-1:0]       slot_free;
  logic [`WBUF_TID_W-1:0]        tid;
  logic                          slot_vld;
  logic                          take;
  byte_mask_t                    take_be;
  logic                          evict;
  logic [`WBUF_PTR_W-1:0]        evict_ptr;
  byte_mask_t                    evict_be;

  for (genvar k = 0; k < `WBUF_DEPTH; k++) begin : gen_req
    assign dirty_req[k] = |sendable[k];
  end

  wbuf_store u_store (
    .clk_i, .rst_ni, .core_req_i, .core_gnt_o,
    .take_i (take), .take_ptr_i (dirty_idx), .take_be_i (take_be),
    .evict_i (evict), .evict_ptr_i (evict_ptr), .evict_be_i (evict_be),
    .entries_o (entries), .sendable_o (sendable), .empty_o
  );

  // entry to drain next, held while memory stalls
  rr_arbiter #(.NUM_REQ(`WBUF_DEPTH)) u_dirty_arb (
    .clk_i, .rst_ni, .req_i (dirty_req), .gnt_i (take), .idx_o (dirty_idx), .vld_o (dirty_vld)
  );

  // transaction ID for that transfer
  rr_arbiter #(.NUM_REQ(`WBUF_MAX_TX)) u_slot_arb (
    .clk_i, .rst_ni, .req_i (slot_free), .gnt_i (take), .idx_o (tid), .vld_o (slot_vld)
  );

  wbuf_tx_issue u_tx_issue (
    .entry_i (entries[dirty_idx]), .sendable_i (sendable[dirty_idx]),
    .sel_vld_i (dirty_vld), .slot_free_i (slot_vld), .tid_i (tid),
    .mem_wreq_o, .mem_ack_i, .take_o (take), .take_be_o (take_be)
  );

  wbuf_tx_tracker u_tx_tracker (
    .clk_i, .rst_ni, .take_i (take), .take_ptr_i (dirty_idx), .take_be_i (take_be),
    .tid_i (tid), .mem_wrsp_i, .slot_free_o (slot_free),
    .evict_o (evict), .evict_ptr_o (evict_ptr), .evict_be_o (evict_be)
  );

endmodule

// ==== tests/tb_write_buffer.sv ====
/*
 * testbench for the coalescing write buffer: random core stores, a memory
 * model that acks at random and answers out of order, image compare
 */

`timescale 1ns/1ps
`include "wbuf_settings.svh"

module tb_write_buffer
  import wbuf_bus_pkg::*;
();

  localparam int          CLK_PERIOD      = 100;
  localparam int          N_TESTS         = 4;
  localparam int          CYCLES_PER_TEST = 4000;
  localparam int          N_WORDS         = 8;
  localparam int          N_BYTES         = N_WORDS * `WBUF_BYTES;
  localparam logic [31:0] BASE_ADDR       = 32'h0000_1000;
  localparam logic [31:0] SEED            = 32'hc471_b2ea;

  // one transfer that memory has taken and not yet answered
  typedef struct packed {
    logic [`WBUF_TID_W-1:0] tid;
    int                     first;
    int                     len;
    int unsigned            ready;
  } xfer_t;

  logic       clk_i      = 1'b0;
  logic       rst_ni     = 1'b0;
  core_wreq_t core_req_i = '0;
  logic       core_gnt_o;
  mem_wreq_t  mem_wreq_o;
  logic       mem_ack_i  = 1'b0;
  mem_wrsp_t  mem_wrsp_i = '0;
  logic       empty_o;

  // expected image from core writes, actual image from memory transfers
  xfer_t       pend[$];
  bit [7:0]    exp_mem [N_BYTES];
  bit [7:0]    act_mem [N_BYTES];
  bit          written [N_BYTES];
  bit          busy    [N_BYTES];
  int unsigned cycle    = 0;
  int          errors   = 0;
  int          n_tests  = 0;
  int          n_failed = 0;
  int          n_xfer   = 0;
  logic [31:0] last_addr;
  logic [1:0]  last_size;
  logic [63:0] last_data;
  bit          prev_gnt = 1'b0;

  write_buffer u_write_buffer (
    .clk_i, .rst_ni, .core_req_i, .core_gnt_o,
    .mem_wreq_o, .mem_ack_i, .mem_wrsp_i, .empty_o
  );

  always #(CLK_PERIOD / 2) clk_i = ~clk_i;

  always @(posedge clk_i) cycle <= cycle + 1;

  task automatic report_error(input string msg);
    errors++;
    $display("error %0t: %s", $time, msg);
  endtask

  ////////////////////////////////////////
  // reference model
  ////////////////////////////////////////

  // transfer that memory takes at the coming edge
  task automatic check_transfer();
    int   len;
    int   base;
    int   lane;
    xfer_t x;
    len  = 1 << mem_wreq_o.size;
    base = int'(mem_wreq_o.addr - BASE_ADDR);
    if (pend.size() >= `WBUF_MAX_TX) begin
      report_error($sformatf("more than %0d transfers outstanding", `WBUF_MAX_TX));
    end
    foreach (pend[i]) begin
      if (pend[i].tid == mem_wreq_o.tid) begin
        report_error($sformatf("tid %0d reused before its response", mem_wreq_o.tid));
      end
    end
    if ((mem_wreq_o.addr % len) != 0) begin
      report_error($sformatf("addr %h not aligned to %0d bytes", mem_wreq_o.addr, len));
    end
    if ((base < 0) || (base + len > N_BYTES)) begin
      report_error($sformatf("addr %h outside the written range", mem_wreq_o.addr));
      return;
    end
    for (int i = 0; i < len; i++) begin
      if (!written[base + i]) begin
        report_error($sformatf("byte %h sent but never written", mem_wreq_o.addr + i));
      end
      if (busy[base + i]) begin
        report_error($sformatf("byte %h already in flight", mem_wreq_o.addr + i));
      end
      lane = (base + i) % `WBUF_BYTES;
      act_mem[base + i] = mem_wreq_o.data[8*lane +: 8];
      busy[base + i]    = 1'b1;
    end
    x.tid   = mem_wreq_o.tid;
    x.first = base;
    x.len   = len;
    x.ready = cycle + 1 + ($urandom % 8);
    pend.push_back(x);
    n_xfer++;
    last_addr = mem_wreq_o.addr;
    last_size = mem_wreq_o.size;
    last_data = mem_wreq_o.data;
  endtask

  // apply a granted core write byte by byte
  task automatic record_write();
    int base;
    base = int'(core_req_i.addr - BASE_ADDR);
    for (int j = 0; j < `WBUF_BYTES; j++) begin
      if (core_req_i.be[j]) begin
        exp_mem[base + j] = core_req_i.data[8*j +: 8];
        written[base + j] = 1'b1;
      end
    end
  endtask

  // sampled at the falling edge while all inputs are stable
  always @(negedge clk_i) begin : p_monitor
    if (rst_ni) begin
      if (prev_gnt && empty_o) begin
        report_error("empty_o high in the cycle after a grant");
      end
      // a rewrite granted in the same cycle lands after the transfer
      if (mem_wreq_o.valid && mem_ack_i) begin
        check_transfer();
      end
      prev_gnt = core_req_i.valid && core_gnt_o;
      if (prev_gnt) begin
        record_write();
      end
    end
  end

  // random ack and at most one response per cycle for any ready transfer
  always @(posedge clk_i) begin : p_responder
    int n;
    int start;
    int pick;
    #1;
    mem_ack_i  = ($urandom % 3) != 0;
    mem_wrsp_i = '0;
    n    = pend.size();
    pick = -1;
    if (n > 0) begin
      start = int'($urandom % n);
      for (int k = 0; k < n; k++) begin
        if ((pick < 0) && (pend[(start + k) % n].ready <= cycle)) begin
          pick = (start + k) % n;
        end
      end
    end
    if ((pick >= 0) && (($urandom % 2) == 0)) begin
      mem_wrsp_i.valid = 1'b1;
      mem_wrsp_i.tid   = pend[pick].tid;
      for (int i = 0; i < pend[pick].len; i++) begin
        busy[pend[pick].first + i] = 1'b0;
      end
      pend.delete(pick);
    end
  end

  ////////////////////////////////////////
  // stimulus
  ////////////////////////////////////////

  task automatic idle(input int n);
    repeat (n) begin
      @(posedge clk_i);
      #1;
    end
  endtask

  // valid stays up until granted and drops 1 ns after the accepting edge
  task automatic write_word(input int widx, input logic [7:0] be, input logic [63:0] data);
    logic granted;
    core_req_i.valid = 1'b1;
    core_req_i.addr  = BASE_ADDR + 32'(widx * `WBUF_BYTES);
    core_req_i.be    = be;
    core_req_i.data  = data;
    granted = 1'b0;
    while (!granted) begin
      @(negedge clk_i);
      granted = core_gnt_o;
      @(posedge clk_i);
      #1;
    end
    core_req_i.valid = 1'b0;
  endtask

  // no writes until every byte is returned and evicted
  task automatic drain_and_compare();
    while (!empty_o) begin
      @(posedge clk_i);
      #1;
    end
    if (pend.size() != 0) begin
      report_error($sformatf("%0d transfers unanswered with empty_o high", pend.size()));
    end
    for (int i = 0; i < N_BYTES; i++) begin
      if (written[i] && (exp_mem[i] != act_mem[i])) begin
        report_error($sformatf("byte %h is %h, expected %h",
                               BASE_ADDR + 32'(i), act_mem[i], exp_mem[i]));
      end
    end
  endtask

  task automatic finish_test(input string name, input int e0);
    n_tests++;
    if (errors == e0) begin
      $display("test %s passed", name);
    end else begin
      n_failed++;
      $display("test %s failed with %0d errors", name, errors - e0);
    end
  endtask

  initial begin : p_main
    int          e0;
    int          n0;
    int          n_wait;
    logic [7:0]  be;
    logic [63:0] data;
    void'($urandom(SEED));
    repeat (8) @(posedge clk_i);
    #1;
    rst_ni = 1'b1;

    // quiet outputs out of reset
    e0 = errors;
    @(negedge clk_i);
    if (!empty_o) report_error("empty_o low after reset");
    if (core_gnt_o) report_error("core_gnt_o high with no request");
    if (mem_wreq_o.valid) report_error("memory request valid after reset");
    idle(1);
    finish_test("reset_state", e0);

    // only 8 words so that hits and merges are common
    e0 = errors;
    for (int i = 0; i < 300; i++) begin
      be = 8'($urandom);
      if (be == '0) be = 8'h01;
      data = {$urandom, $urandom};
      write_word(int'($urandom % N_WORDS), be, data);
      idle(int'($urandom % 4));
    end
    drain_and_compare();
    finish_test("random_burst", e0);

    // a single byte goes out and empty_o rises soon after its eviction
    e0 = errors;
    n0 = n_xfer;
    write_word(3, 8'h10, {$urandom, $urandom});
    if (empty_o) report_error("empty_o high after a granted write");
    while ((n_xfer == n0) || (pend.size() != 0)) begin
      @(negedge clk_i);
    end
    // response is queued, then evicted, then the buffer is empty
    n_wait = 0;
    while (!empty_o && (n_wait < 4)) begin
      @(negedge clk_i);
      n_wait++;
    end
    if (!empty_o) begin
      report_error("empty_o still low after the last response was evicted");
    end
    idle(1);
    drain_and_compare();
    finish_test("empty_flag", e0);

    // full word into an empty buffer goes out as one 8 byte transfer
    e0   = errors;
    n0   = n_xfer;
    data = {$urandom, $urandom};
    write_word(5, 8'hff, data);
    drain_and_compare();
    if (n_xfer != n0 + 1) begin
      report_error($sformatf("full word sent as %0d transfers", n_xfer - n0));
    end
    if (last_size != 2'd3) report_error($sformatf("size code %0d, expected 3", last_size));
    if (last_addr != BASE_ADDR + 32'd40) begin
      report_error($sformatf("addr %h, expected %h", last_addr, BASE_ADDR + 32'd40));
    end
    if (last_data != data) report_error($sformatf("data %h, expected %h", last_data, data));
    finish_test("full_word", e0);

    $display("tests run %0d, passed %0d, failed %0d, errors %0d",
             n_tests, n_tests - n_failed, n_failed, errors);
    if ((n_failed == 0) && (errors == 0)) begin
      $display("Everything OK");
    end else begin
      $display("Something failed");
    end
    $finish;
  end

  initial begin : p_watchdog
    #(N_TESTS * CYCLES_PER_TEST * CLK_PERIOD);
    $display("watchdog: run did not finish within %0d cycles", N_TESTS * CYCLES_PER_TEST);
    $display("Something failed");
    $finish;
  end

endmodule

// ==== sim.f ====
+incdir+include
source/wbuf_entry_pkg.sv
source/wbuf_bus_pkg.sv
source/rr_arbiter.sv
source/wbuf_store.sv
source/wbuf_tx_issue.sv
source/wbuf_tx_tracker.sv
source/write_buffer.sv
tests/tb_write_buffer.sv

// ==== Makefile ====
# Verilator build and run of the write buffer testbench

BIN  := obj_dir/Vtb_write_buffer
SRCS := $(wildcard source/*.sv tests/*.sv include/*.svh)

.PHONY: all run clean

all: run

# rebuilt only when a source or the file list changes
$(BIN): sim.f $(SRCS)
	verilator --binary --timing --assert -Wno-fatal -j 0 \
	  --top-module tb_write_buffer -f sim.f

# pass only if the run prints the pass line
run: $(BIN)
	@out="$$(./$(BIN))"; echo "$$out"; echo "$$out" | grep -qx "Everything OK"

clean:
	rm -rf obj_dir
